//--- hw/core_settings.svh
////////////////////////////////////////////////////////////////////////////
// Channelised arithmetic core
// Sizes of the datapath, program store and register banks, and host map
////////////////////////////////////////////////////////////////////////////

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define CORE_DATA_WIDTH   32
`define CORE_PROG_DEPTH   64
`define CORE_CHANNELS     4
`define CORE_REGS_PER_CH  16
// Shortest instruction round, covers the read-after-write distance
`define CORE_MIN_ROUND    3

// Host address map
`define CORE_ADDR_WIDTH   12
`define CORE_ADDR_CTRL    12'h000
`define CORE_ADDR_NCH     12'h004
`define CORE_ADDR_PROG    12'h100
`define CORE_ADDR_REGS    12'h200

`endif

//--- hw/core_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Channelised arithmetic core types
// Opcodes, control states, pipeline records and AXI4-Lite bundles
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "core_settings.svh"

package core_pkg;

    localparam int DATA_W  = `CORE_DATA_WIDTH;
    localparam int PC_W    = $clog2(`CORE_PROG_DEPTH);
    localparam int CH_W    = $clog2(`CORE_CHANNELS);
    localparam int REG_W   = $clog2(`CORE_REGS_PER_CH);
    localparam int RADDR_W = CH_W + REG_W;
    localparam int ADDR_W  = `CORE_ADDR_WIDTH;

    typedef enum logic [4:0] {
        OP_NOP, OP_LDI, OP_CHID, OP_ADD, OP_SUB, OP_MUL,
        OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_STOP
    } opcode_e;

    typedef enum logic [1:0] {IDLE, RUN, DRAIN} ctrl_state_e;

    // Instruction word, opcode in the top bits
    typedef struct packed {
        opcode_e          opcode;
        logic [REG_W-1:0] dest;
        logic [REG_W-1:0] src_a;
        logic [REG_W-1:0] src_b;
        logic [14:0]      imm;
    } instr_t;

    typedef struct packed {
        logic            valid;
        logic [PC_W-1:0] pc;
        logic [CH_W-1:0] channel;
    } slot_t;

    typedef struct packed {
        logic             valid;
        opcode_e          opcode;
        logic [CH_W-1:0]  channel;
        logic [REG_W-1:0] dest;
        logic [14:0]      imm;
    } op_t;

    typedef struct packed {
        logic               valid;
        logic [RADDR_W-1:0] addr;
        logic [DATA_W-1:0]  data;
    } result_t;

    typedef struct packed {
        logic              awvalid;
        logic [ADDR_W-1:0] awaddr;
        logic              wvalid;
        logic [DATA_W-1:0] wdata;
        logic              bready;
        logic              arvalid;
        logic [ADDR_W-1:0] araddr;
        logic              rready;
    } axil_req_t;

    typedef struct packed {
        logic              awready;
        logic              wready;
        logic              bvalid;
        logic [1:0]        bresp;
        logic              arready;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
        logic [1:0]        rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

//--- hw/core_control.sv
////////////////////////////////////////////////////////////////////////////
// Core control unit
// Sequences the program counter over all active channels, pads short
// rounds, drains the pipeline after a stop and flags completion
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module core_control import core_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        start,
    input  logic [1:0]  nch_m1,
    input  logic        halt,
    output slot_t       slot,
    output logic        busy,
    output logic        done
);

    localparam int ROUND_MAX    = (`CORE_CHANNELS > `CORE_MIN_ROUND) ?
                                  `CORE_CHANNELS : `CORE_MIN_ROUND;
    localparam int CYC_W        = $clog2(ROUND_MAX);
    localparam int DRAIN_CYCLES = 2;
    localparam int DRAIN_W      = $clog2(DRAIN_CYCLES);

    ctrl_state_e        state;
    logic [PC_W-1:0]    pc;
    logic [CYC_W-1:0]   cyc;
    logic [CYC_W-1:0]   last_cyc;
    logic [DRAIN_W-1:0] drain_cnt;

    // Round length is the channel count, but never below the minimum round
    assign last_cyc = (CYC_W'(nch_m1) > CYC_W'(`CORE_MIN_ROUND - 1)) ?
                      CYC_W'(nch_m1) : CYC_W'(`CORE_MIN_ROUND - 1);

    assign busy = (state != IDLE);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            pc        <= '0;
            cyc       <= '0;
            drain_cnt <= '0;
            slot      <= '0;
            done      <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    slot.valid <= 1'b0;
                    if (start) begin
                        state <= RUN;
                        pc    <= '0;
                        cyc   <= '0;
                        done  <= 1'b0;
                    end
                end
                RUN: begin
                    if (halt) begin
                        state      <= DRAIN;
                        slot.valid <= 1'b0;
                        drain_cnt  <= '0;
                    end else begin
                        // Slots past the last channel are padding
                        slot.valid   <= (cyc <= CYC_W'(nch_m1));
                        slot.pc      <= pc;
                        slot.channel <= CH_W'(cyc);
                        if (cyc == last_cyc) begin
                            cyc <= '0;
                            pc  <= pc + 1'b1;
                        end else begin
                            cyc <= cyc + 1'b1;
                        end
                    end
                end
                DRAIN: begin
                    slot.valid <= 1'b0;
                    if (drain_cnt == DRAIN_W'(DRAIN_CYCLES - 1)) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/core_decoder.sv
////////////////////////////////////////////////////////////////////////////
// Instruction decoder
// Aligns issue slots with fetched words, addresses the operand banks
// and registers the operation for the execution stage
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module core_decoder import core_pkg::*; (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               start,
    input  slot_t              slot,
    input  instr_t             instr,
    output logic [RADDR_W-1:0] rd_addr_a,
    output logic [RADDR_W-1:0] rd_addr_b,
    output op_t                op,
    output logic               halt
);

    slot_t slot_q;
    logic  halted;
    logic  live;

    // A slot counts only until the first stop of the run
    assign live = slot_q.valid && !halted;
    assign halt = live && (instr.opcode == OP_STOP);

    // Operands come from the bank of the slot's channel
    assign rd_addr_a = {slot_q.channel, instr.src_a};
    assign rd_addr_b = {slot_q.channel, instr.src_b};

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            slot_q <= '0;
            halted <= 1'b0;
            op     <= '0;
        end else begin
            slot_q <= slot;
            if (start) begin
                halted <= 1'b0;
            end else if (halt) begin
                halted <= 1'b1;
            end
            op.valid   <= live && (instr.opcode != OP_NOP) && (instr.opcode != OP_STOP);
            op.opcode  <= instr.opcode;
            op.channel <= slot_q.channel;
            op.dest    <= instr.dest;
            op.imm     <= instr.imm;
        end
    end

endmodule

`default_nettype wire

//--- hw/core_alu.sv
////////////////////////////////////////////////////////////////////////////
// Integer execution stage
// One registered stage turning an operation into a register write-back
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module core_alu import core_pkg::*; (
    input  logic              clock,
    input  logic              rst_n,
    input  op_t               op,
    input  logic [DATA_W-1:0] opnd_a,
    input  logic [DATA_W-1:0] opnd_b,
    output result_t           result
);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result.valid <= op.valid;
            result.addr  <= {op.channel, op.dest};
            case (op.opcode)
                OP_LDI:  result.data <= DATA_W'(op.imm);
                OP_CHID: result.data <= DATA_W'(op.channel);
                OP_ADD:  result.data <= opnd_a + opnd_b;
                OP_SUB:  result.data <= opnd_a - opnd_b;
                // Low half of the product only
                OP_MUL:  result.data <= opnd_a * opnd_b;
                OP_AND:  result.data <= opnd_a & opnd_b;
                OP_OR:   result.data <= opnd_a | opnd_b;
                OP_XOR:  result.data <= opnd_a ^ opnd_b;
                OP_SHL:  result.data <= opnd_a << opnd_b[4:0];
                OP_SHR:  result.data <= opnd_a >> opnd_b[4:0];
                default: result.data <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/core_register_file.sv
////////////////////////////////////////////////////////////////////////////
// Banked register file
// One bank of registers per channel, two operand ports and a host port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module core_register_file import core_pkg::*; (
    input  logic               clock,
    input  logic [RADDR_W-1:0] rd_addr_a,
    input  logic [RADDR_W-1:0] rd_addr_b,
    input  logic [RADDR_W-1:0] host_addr,
    output logic [DATA_W-1:0]  rd_data_a,
    output logic [DATA_W-1:0]  rd_data_b,
    output logic [DATA_W-1:0]  host_data,
    input  result_t            wr
);

    localparam int DEPTH = `CORE_CHANNELS * `CORE_REGS_PER_CH;

    // Address is {channel, register}, so banks sit side by side
    logic [DATA_W-1:0] regs [DEPTH];

    always_ff @(posedge clock) begin
        if (wr.valid) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // All read ports return the value held before a same-edge write
    always_ff @(posedge clock) begin
        rd_data_a <= regs[rd_addr_a];
        rd_data_b <= regs[rd_addr_b];
        host_data <= regs[host_addr];
    end

endmodule

`default_nettype wire

//--- hw/core_host_port.sv
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite host port
// Program store, run control, channel count and register readback
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module core_host_port import core_pkg::*; (
    input  logic               clock,
    input  logic               rst_n,
    input  axil_req_t          axil_req,
    output axil_rsp_t          axil_rsp,
    input  slot_t              slot,
    output instr_t             instr,
    output logic               start,
    output logic [1:0]         nch_m1,
    input  logic               busy,
    input  logic               done,
    output logic [RADDR_W-1:0] reg_addr,
    input  logic [DATA_W-1:0]  reg_data
);

    localparam logic [ADDR_W-1:0] PROG_END = `CORE_ADDR_PROG + 4 * `CORE_PROG_DEPTH;
    localparam logic [ADDR_W-1:0] REGS_END = `CORE_ADDR_REGS +
                                             4 * `CORE_CHANNELS * `CORE_REGS_PER_CH;

    instr_t             prog [`CORE_PROG_DEPTH];
    logic               wr_fire;
    logic               rd_fire;
    logic               rd_is_reg;
    logic               rd_is_reg_q;
    logic [DATA_W-1:0]  rd_value;
    logic [DATA_W-1:0]  rdata_q;
    logic [RADDR_W-1:0] reg_addr_q;

    assign wr_fire   = axil_req.awvalid && axil_req.wvalid && !axil_rsp.bvalid;
    assign rd_fire   = axil_req.arvalid && !axil_rsp.rvalid;
    assign rd_is_reg = (axil_req.araddr >= `CORE_ADDR_REGS) && (axil_req.araddr < REGS_END);

    assign axil_rsp.awready = wr_fire;
    assign axil_rsp.wready  = wr_fire;
    assign axil_rsp.bresp   = 2'b00;
    assign axil_rsp.arready = rd_fire;
    assign axil_rsp.rresp   = 2'b00;
    assign axil_rsp.rdata   = rd_is_reg_q ? reg_data : rdata_q;

    // Hold the register address while a read response waits for rready
    assign reg_addr = axil_rsp.rvalid ? reg_addr_q : axil_req.araddr[RADDR_W+1:2];

    always_comb begin
        rd_value = '0;
        if (axil_req.araddr == `CORE_ADDR_CTRL) begin
            rd_value = DATA_W'({done, busy});
        end else if (axil_req.araddr == `CORE_ADDR_NCH) begin
            rd_value = DATA_W'(nch_m1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Handshake and control registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            axil_rsp.bvalid <= 1'b0;
            axil_rsp.rvalid <= 1'b0;
            rd_is_reg_q     <= 1'b0;
            start           <= 1'b0;
            nch_m1          <= 2'd0;
        end else begin
            if (wr_fire) begin
                axil_rsp.bvalid <= 1'b1;
            end else if (axil_req.bready) begin
                axil_rsp.bvalid <= 1'b0;
            end
            if (rd_fire) begin
                axil_rsp.rvalid <= 1'b1;
                rd_is_reg_q     <= rd_is_reg;
            end else if (axil_req.rready) begin
                axil_rsp.rvalid <= 1'b0;
            end
            // A start while a run is in progress is dropped
            start <= wr_fire && (axil_req.awaddr == `CORE_ADDR_CTRL) &&
                     axil_req.wdata[0] && !busy;
            if (wr_fire && (axil_req.awaddr == `CORE_ADDR_NCH)) begin
                nch_m1 <= axil_req.wdata[1:0];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Program store and read data
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (wr_fire && (axil_req.awaddr >= `CORE_ADDR_PROG) && (axil_req.awaddr < PROG_END)) begin
            prog[axil_req.awaddr[PC_W+1:2]] <= instr_t'(axil_req.wdata);
        end
        if (slot.valid) begin
            instr <= prog[slot.pc];
        end
        if (rd_fire) begin
            rdata_q    <= rd_value;
            reg_addr_q <= axil_req.araddr[RADDR_W+1:2];
        end
    end

endmodule

`default_nettype wire

//--- hw/core_top.sv
////////////////////////////////////////////////////////////////////////////
// Channelised arithmetic core, top level
// Host port, control, decoder, ALU and banked register file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module core_top import core_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output logic      done
);

    slot_t              slot;
    instr_t             instr;
    op_t                op;
    result_t            result;
    logic               start;
    logic               busy;
    logic               halt;
    logic [1:0]         nch_m1;
    logic [RADDR_W-1:0] rd_addr_a;
    logic [RADDR_W-1:0] rd_addr_b;
    logic [RADDR_W-1:0] reg_addr;
    logic [DATA_W-1:0]  opnd_a;
    logic [DATA_W-1:0]  opnd_b;
    logic [DATA_W-1:0]  reg_data;

    core_host_port i_host_port (
        .clock(clock), .rst_n(rst_n), .axil_req(axil_req), .axil_rsp(axil_rsp),
        .slot(slot), .instr(instr), .start(start), .nch_m1(nch_m1), .busy(busy),
        .done(done), .reg_addr(reg_addr), .reg_data(reg_data)
    );

    core_control i_control (
        .clock(clock), .rst_n(rst_n), .start(start), .nch_m1(nch_m1), .halt(halt),
        .slot(slot), .busy(busy), .done(done)
    );

    core_decoder i_decoder (
        .clock(clock), .rst_n(rst_n), .start(start), .slot(slot), .instr(instr),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b), .op(op), .halt(halt)
    );

    core_alu i_alu (
        .clock(clock), .rst_n(rst_n), .op(op), .opnd_a(opnd_a), .opnd_b(opnd_b),
        .result(result)
    );

    core_register_file i_register_file (
        .clock(clock), .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b), .host_addr(reg_addr),
        .rd_data_a(opnd_a), .rd_data_b(opnd_b), .host_data(reg_data), .wr(result)
    );

endmodule

`default_nettype wire

//--- sim/core_asserts.sv
////////////////////////////////////////////////////////////////////////////
// Protocol checks for the core
// Run status, issue channel range and AXI4-Lite response holding
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module core_asserts import core_pkg::*; (
    input logic       clock,
    input logic       rst_n,
    input logic       busy,
    input logic       done,
    input slot_t      slot,
    input logic [1:0] nch_m1,
    input axil_req_t  axil_req,
    input axil_rsp_t  axil_rsp
);

    int fail_count = 0;

    // A run is either in progress or finished
    busy_done_excl: assert property (@(posedge clock) disable iff (!rst_n)
        !(busy && done))
        else begin
            $error("busy and done are high together");
            fail_count++;
        end

    slot_channel_range: assert property (@(posedge clock) disable iff (!rst_n)
        slot.valid |-> (slot.channel <= nch_m1))
        else begin
            $error("valid slot addresses an inactive channel");
            fail_count++;
        end

    bvalid_hold: assert property (@(posedge clock) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else begin
            $error("bvalid dropped before bready");
            fail_count++;
        end

    // Read data must not change while the response waits
    rvalid_hold: assert property (@(posedge clock) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
        else begin
            $error("rvalid or rdata changed before rready");
            fail_count++;
        end

endmodule

bind core_control core_asserts i_ctrl_asserts (
    .clock(clock), .rst_n(rst_n), .busy(busy), .done(done), .slot(slot),
    .nch_m1(nch_m1), .axil_req('0), .axil_rsp('0)
);

bind core_host_port core_asserts i_host_asserts (
    .clock(clock), .rst_n(rst_n), .busy(busy), .done(done), .slot(slot),
    .nch_m1(nch_m1), .axil_req(axil_req), .axil_rsp(axil_rsp)
);

`default_nettype wire

//--- sim/core_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the channelised arithmetic core
// Loads programs over AXI4-Lite, runs them and checks every register bank
// against a per-channel reference model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module core_tb import core_pkg::*; ();

    localparam int NREGS      = `CORE_CHANNELS * `CORE_REGS_PER_CH;
    localparam int NUM_RANDOM = 20;
    // Load, run and full readback of one program with back-pressure
    localparam int PROG_CYCLES    = 2000;
    localparam int TIMEOUT_CYCLES = (NUM_RANDOM + 4) * PROG_CYCLES;

    logic      clock;
    logic      rst_n;
    axil_req_t req;
    axil_rsp_t rsp;
    logic      done;

    instr_t            prog_q [$];
    logic [DATA_W-1:0] model_regs [NREGS];
    logic              model_known [NREGS];
    int                bp_max;
    int                cycles = 0;

    core_top i_core_top (
        .clock(clock), .rst_n(rst_n), .axil_req(req), .axil_rsp(rsp), .done(done)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: the test sequence did not end within %0d cycles",
                     TIMEOUT_CYCLES);
            fail_run();
        end
    end

    // Stop at the first failed protocol assertion
    always @(negedge clock) begin
        if (i_core_top.i_control.i_ctrl_asserts.fail_count +
            i_core_top.i_host_port.i_host_asserts.fail_count != 0) begin
            $display("A bound protocol assertion failed");
            fail_run();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_run();
        $display("Something failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    // Status pair is {done, busy}
    task automatic check_status(input string name, input logic [1:0] got,
                                input logic [1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got,
                              input logic [1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    // Single-bit outputs such as the done pin and the ready lines
    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // AXI4-Lite driver
    ////////////////////////////////////////////////////////////////////////////

    task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        int stall;
        stall = $urandom_range(0, bp_max);
        @(negedge clock);
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        req.wvalid  = 1'b1;
        req.wdata   = data;
        // Mid low phase, no response is pending so both readies are up
        #2;
        check_flag("awready", rsp.awready, 1'b1);
        check_flag("wready", rsp.wready, 1'b1);
        @(negedge clock);
        while (!rsp.bvalid) begin
            @(negedge clock);
        end
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        check_resp("bresp", rsp.bresp, 2'b00);
        repeat (stall) @(negedge clock);
        req.bready = 1'b1;
        @(negedge clock);
        req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        int stall;
        stall = $urandom_range(0, bp_max);
        @(negedge clock);
        req.arvalid = 1'b1;
        req.araddr  = addr;
        // Mid low phase, no read response is pending
        #2;
        check_flag("arready", rsp.arready, 1'b1);
        @(negedge clock);
        while (!rsp.rvalid) begin
            @(negedge clock);
        end
        req.arvalid = 1'b0;
        data = rsp.rdata;
        check_resp("rresp", rsp.rresp, 2'b00);
        repeat (stall) @(negedge clock);
        check_data("rdata held under back-pressure", rsp.rdata, data);
        req.rready = 1'b1;
        @(negedge clock);
        req.rready = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Programs and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic void push_instr(input opcode_e opc, input int dest, input int src_a,
                                       input int src_b, input int imm);
        instr_t w;
        w.opcode = opc;
        w.dest   = REG_W'(dest);
        w.src_a  = REG_W'(src_a);
        w.src_b  = REG_W'(src_b);
        w.imm    = 15'(imm);
        prog_q.push_back(w);
    endfunction

    // Channels never share registers, so each one runs the whole program in turn
    function automatic void ref_run(input int nch);
        instr_t            w;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] r;
        int                base;
        for (int ch = 0; ch < nch; ch++) begin
            base = ch * `CORE_REGS_PER_CH;
            for (int pc = 0; pc < prog_q.size(); pc++) begin
                w = prog_q[pc];
                if (w.opcode == OP_STOP) begin
                    break;
                end
                a = model_regs[base + w.src_a];
                b = model_regs[base + w.src_b];
                case (w.opcode)
                    OP_LDI:  r = {17'd0, w.imm};
                    OP_CHID: r = ch;
                    OP_ADD:  r = a + b;
                    OP_SUB:  r = a - b;
                    OP_MUL:  r = a * b;
                    OP_AND:  r = a & b;
                    OP_OR:   r = a | b;
                    OP_XOR:  r = a ^ b;
                    OP_SHL:  r = a << b[4:0];
                    OP_SHR:  r = a >> b[4:0];
                    default: r = '0;
                endcase
                if (w.opcode != OP_NOP) begin
                    model_regs[base + w.dest]  = r;
                    model_known[base + w.dest] = 1'b1;
                end
            end
        end
    endfunction

    // Loads first, then operations that only read registers already written
    task automatic gen_random_program();
        logic [15:0] avail;
        int          len;
        int          nload;
        int          dest;
        int          pick [2];
        opcode_e     opc;
        prog_q.delete();
        avail = '0;
        nload = $urandom_range(2, 4);
        len   = $urandom_range(nload + 1, 30);
        for (int i = 0; i < nload; i++) begin
            push_instr(OP_LDI, i, 0, 0, $urandom_range(0, 32767));
            avail[i] = 1'b1;
        end
        for (int i = nload; i < len; i++) begin
            opc  = opcode_e'($urandom_range(0, 10));
            dest = $urandom_range(0, 15);
            for (int k = 0; k < 2; k++) begin
                pick[k] = $urandom_range(0, 15);
                while (!avail[pick[k]]) begin
                    pick[k] = $urandom_range(0, 15);
                end
            end
            push_instr(opc, dest, pick[0], pick[1], $urandom_range(0, 32767));
            if (opc != OP_NOP) begin
                avail[dest] = 1'b1;
            end
        end
        push_instr(OP_STOP, 0, 0, 0, 0);
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_q.size(); i++) begin
            axil_write(ADDR_W'(`CORE_ADDR_PROG + 4 * i), DATA_W'(prog_q[i]));
        end
    endtask

    task automatic wait_done();
        logic [DATA_W-1:0] st;
        st = '0;
        while (!st[1]) begin
            axil_read(`CORE_ADDR_CTRL, st);
        end
        check_status("status at end of run", st[1:0], 2'b10);
        check_flag("done at end of run", done, 1'b1);
    endtask

    task automatic compare_banks();
        logic [DATA_W-1:0] rd;
        for (int i = 0; i < NREGS; i++) begin
            if (model_known[i]) begin
                axil_read(ADDR_W'(`CORE_ADDR_REGS + 4 * i), rd);
                check_data($sformatf("bank %0d r%0d", i / `CORE_REGS_PER_CH,
                                     i % `CORE_REGS_PER_CH), rd, model_regs[i]);
            end
        end
    endtask

    task automatic run_program(input int nch);
        load_program();
        axil_write(`CORE_ADDR_NCH, DATA_W'(nch - 1));
        axil_write(`CORE_ADDR_CTRL, 32'd1);
        ref_run(nch);
        wait_done();
        compare_banks();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [DATA_W-1:0] rd;
        logic [ADDR_W-1:0] holes [4];
        int                asserts_failed;
        void'($urandom(32'h102e));
        clock  = 1'b0;
        rst_n  = 1'b0;
        req    = '0;
        bp_max = 0;
        holes  = '{12'h008, 12'h104, 12'h300, 12'hffc};
        foreach (model_known[i]) begin
            model_known[i] = 1'b0;
        end
        repeat (8) @(negedge clock);
        rst_n = 1'b1;

        // Idle after reset, one channel
        axil_read(`CORE_ADDR_CTRL, rd);
        check_status("status after reset", rd[1:0], 2'b00);
        check_flag("done after reset", done, 1'b0);
        axil_read(`CORE_ADDR_NCH, rd);
        check_data("channel count after reset", rd, 32'd0);

        // Every opcode on one channel
        prog_q.delete();
        push_instr(OP_LDI, 1, 0, 0, 'h1234);
        push_instr(OP_LDI, 2, 0, 0, 5);
        push_instr(OP_LDI, 3, 0, 0, 'h7fff);
        push_instr(OP_ADD, 4, 1, 2, 0);
        push_instr(OP_SUB, 5, 2, 1, 0);
        push_instr(OP_MUL, 6, 1, 3, 0);
        push_instr(OP_AND, 7, 1, 3, 0);
        push_instr(OP_OR, 8, 1, 2, 0);
        push_instr(OP_XOR, 9, 1, 3, 0);
        push_instr(OP_SHL, 10, 3, 2, 0);
        push_instr(OP_SHR, 11, 6, 2, 0);
        push_instr(OP_NOP, 12, 1, 1, 0);
        // Product wraps past 32 bits
        push_instr(OP_MUL, 13, 6, 6, 0);
        push_instr(OP_STOP, 0, 0, 0, 0);
        run_program(1);

        // Channel id drives different results per bank
        prog_q.delete();
        push_instr(OP_CHID, 0, 0, 0, 0);
        push_instr(OP_LDI, 1, 0, 0, 100);
        push_instr(OP_MUL, 2, 0, 1, 0);
        push_instr(OP_ADD, 3, 2, 0, 0);
        push_instr(OP_LDI, 4, 0, 0, 1);
        push_instr(OP_SHL, 5, 4, 0, 0);
        push_instr(OP_SUB, 6, 3, 5, 0);
        push_instr(OP_XOR, 7, 6, 2, 0);
        push_instr(OP_STOP, 0, 0, 0, 0);
        run_program(4);

        // Random programs and channel counts under back-pressure
        bp_max = 4;
        for (int p = 0; p < NUM_RANDOM; p++) begin
            gen_random_program();
            run_program($urandom_range(1, 4));
        end

        // Accumulating program, so a second run would show in r5
        prog_q.delete();
        push_instr(OP_LDI, 5, 0, 0, 10);
        push_instr(OP_LDI, 6, 0, 0, 3);
        push_instr(OP_STOP, 0, 0, 0, 0);
        run_program(4);
        prog_q.delete();
        for (int i = 0; i < 24; i++) begin
            push_instr(OP_ADD, 5, 5, 6, 0);
        end
        push_instr(OP_STOP, 0, 0, 0, 0);
        load_program();
        axil_write(`CORE_ADDR_CTRL, 32'd1);
        ref_run(4);
        axil_read(`CORE_ADDR_CTRL, rd);
        check_status("status while running", rd[1:0], 2'b01);
        check_flag("done while running", done, 1'b0);
        axil_write(`CORE_ADDR_CTRL, 32'd1);
        wait_done();
        compare_banks();
        axil_read(`CORE_ADDR_NCH, rd);
        check_data("channel count", rd, 32'd3);
        foreach (holes[i]) begin
            axil_read(holes[i], rd);
            check_data($sformatf("unmapped read at %h", holes[i]), rd, 32'd0);
        end

        asserts_failed = i_core_top.i_control.i_ctrl_asserts.fail_count +
                         i_core_top.i_host_port.i_host_asserts.fail_count;
        if (asserts_failed == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", asserts_failed);
            fail_run();
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hw
hw/core_pkg.sv
hw/core_control.sv
hw/core_decoder.sv
hw/core_alu.sv
hw/core_register_file.sv
hw/core_host_port.sv
hw/core_top.sv
sim/core_asserts.sv
sim/core_tb.sv

//--- Makefile
# Verilator flow for the channelised arithmetic core

TOP = core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	@if grep -q "Something failed" sim.log; then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "Everything OK" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
